/* bench/fft_acc_tb.sv */
// Simulation top that runs a packet table through fft_acc_top and checks every reply word
module fft_acc_tb import fft_acc_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int       NUM_TESTS     = 13;
   localparam int       NO_OUT_WINDOW = 50;      // Cycles watched for stray output
   localparam node_id_t TILE_ID       = 6'h2d;

   typedef struct packed {
      logic       is_ctrl;     // Short control packet
      route_t     route;
      size_code_t size;
      node_id_t   low;
      node_id_t   src;
      logic       stall;       // Random out_ready gaps
      logic       expect_out;
   } test_row_t;

   // kind, route, size, low, source, stall, reply expected
   test_row_t rows [NUM_TESTS] = '{
      '{1'b0, 2'b01, 4'd4, 6'h15, 6'h0c, 1'b0, 1'b0},   // Still disabled
      '{1'b1, 2'b00, 4'd0, 6'h00, 6'h00, 1'b0, 1'b0},   // Enable
      '{1'b0, 2'b01, 4'd4, 6'h2b, 6'h11, 1'b0, 1'b1},
      '{1'b0, 2'b10, 4'd4, 6'h3e, 6'h07, 1'b0, 1'b1},
      '{1'b0, 2'b00, 4'd4, 6'h19, 6'h23, 1'b0, 1'b1},
      '{1'b0, 2'b01, 4'd6, 6'h05, 6'h30, 1'b0, 1'b1},   // Four blocks
      '{1'b0, 2'b11, 4'd5, 6'h2a, 6'h01, 1'b1, 1'b1},
      '{1'b0, 2'b10, 4'd6, 6'h33, 6'h3f, 1'b1, 1'b1},
      '{1'b0, 2'b01, 4'd4, 6'h0f, 6'h14, 1'b1, 1'b1},
      '{1'b1, 2'b00, 4'd0, 6'h00, 6'h00, 1'b0, 1'b0},   // Disable
      '{1'b0, 2'b00, 4'd4, 6'h21, 6'h09, 1'b0, 1'b0},
      '{1'b1, 2'b00, 4'd0, 6'h00, 6'h00, 1'b0, 1'b0},   // Enable again
      '{1'b0, 2'b10, 4'd5, 6'h12, 6'h2e, 1'b0, 1'b1}
   };

   logic     clk_ctrl;
   logic     clk_ctrl_rst_low;
   node_id_t src_tile;
   logic     in_valid;
   word_t    in_data;
   logic     in_last;
   logic     in_ready;
   logic     out_valid;
   word_t    out_data;
   logic     out_last;
   logic     out_ready;

   word_t pkt_samples [$];    // Data words of the packet being sent
   word_t exp_data [$];
   logic  exp_last [$];
   int    exp_test [$];
   int    test_errs [NUM_TESTS];
   int    got_words [NUM_TESTS];
   int    err_count = 0;
   int    cur_test  = 0;
   int    in_stalls = 0;
   logic  stall_on  = 1'b0;

   fft_acc_top u_dut (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .src_tile        (src_tile),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_last         (in_last),
      .in_ready        (in_ready),
      .out_valid       (out_valid),
      .out_data        (out_data),
      .out_last        (out_last),
      .out_ready       (out_ready)
   );

   initial begin
      clk_ctrl = 1'b0;
      forever #2 clk_ctrl = ~clk_ctrl;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic word_t reply_hdr1(test_row_t r);
      word_t h;
      h         = '0;
      h[28]     = 1'b1;
      h[27:25]  = (r.route == 2'b10) ? 3'd3 : 3'd4;    // QPUT on final send and MPUT otherwise
      h[23:18]  = TILE_ID;
      h[11:8]   = r.size;
      h[5:0]    = (r.route == 2'b01 || r.route == 2'b10) ? r.low : 6'h00;
      return h;
   endfunction

   function automatic word_t reply_hdr2(test_row_t r);
      if (r.route == 2'b01)
         return {22'h0, 2'b10, 2'b00, r.src};   // Back to the source
      return '0;
   endfunction

   // Sum of samples k and k+4 in the low half and their difference in the high half
   task automatic queue_reply(input int t, input test_row_t r);
      int    nblk;
      word_t a;
      word_t c;
      nblk = pkt_samples.size() / 16;
      exp_data.push_back(reply_hdr1(r));
      exp_last.push_back(1'b0);
      exp_test.push_back(t);
      exp_data.push_back(reply_hdr2(r));
      exp_last.push_back(1'b0);
      exp_test.push_back(t);
      for (int b = 0; b < nblk; b++) begin
         for (int w = 0; w < 16; w++) begin
            a = (w < 8) ? pkt_samples[b*16 + w] : pkt_samples[b*16 + w - 8];
            c = (w < 8) ? pkt_samples[b*16 + w + 8] : pkt_samples[b*16 + w];
            exp_data.push_back((w < 8) ? a + c : a - c);
            exp_last.push_back(b == nblk - 1 && w == 15);
            exp_test.push_back(t);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Drivers
   //////////////////////////////////////////////////

   // Called 1 ns after a rising edge and returns 1 ns after the transfer edge
   task automatic send_word(input word_t d, input logic l);
      in_valid = 1'b1;
      in_data  = d;
      in_last  = l;
      @(posedge clk_ctrl);
      while (!in_ready) begin
         in_stalls++;
         @(posedge clk_ctrl);
      end
      #1;
   endtask

   task automatic send_long(input test_row_t r);
      word_t h1;
      word_t h2;
      h1        = '0;
      h1[28]    = 1'b1;
      h1[23:18] = r.src;
      h1[11:8]  = r.size;
      h2        = '0;
      h2[9:8]   = r.route;
      h2[5:0]   = r.low;
      send_word(h1, 1'b0);
      send_word(h2, 1'b0);
      for (int n = 0; n < pkt_samples.size(); n++)
         send_word(pkt_samples[n], n == pkt_samples.size() - 1);
      in_valid = 1'b0;
      in_last  = 1'b0;
   endtask

   task automatic make_samples(input size_code_t sz);
      pkt_samples.delete();
      repeat (16 << (sz - 4))
         pkt_samples.push_back($urandom);
   endtask

   task automatic wait_drain();
      if (exp_data.size() != 0) begin
         while (exp_data.size() != 0) @(posedge clk_ctrl);
         #1;
      end
   endtask

   initial begin
      out_ready = 1'b1;
      forever begin
         @(posedge clk_ctrl);
         #1;
         out_ready = stall_on ? ($urandom % 2 == 1) : 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Output checker
   //////////////////////////////////////////////////

   initial begin
      word_t prev_data;
      logic  prev_last;
      logic  prev_hold;
      word_t ed;
      logic  el;
      int    et;
      prev_hold = 1'b0;
      forever begin
         @(posedge clk_ctrl);
         if (clk_ctrl_rst_low) begin
            if (prev_hold && (out_data !== prev_data || out_last !== prev_last)) begin
               $display("ERR out_data not held under back-pressure: got %h expected %h",
                        out_data, prev_data);
               err_count++;
               test_errs[cur_test]++;
            end
            if (out_valid && out_ready) begin
               if (exp_data.size() == 0) begin
                  $display("unexpected output word %h while no reply was pending", out_data);
                  err_count++;
                  test_errs[cur_test]++;
               end else begin
                  ed = exp_data.pop_front();
                  el = exp_last.pop_front();
                  et = exp_test.pop_front();
                  if (out_data !== ed) begin
                     $display("ERR out_data test %0d word %0d: got %h expected %h",
                              et, got_words[et], out_data, ed);
                     err_count++;
                     test_errs[et]++;
                  end
                  if (out_last !== el) begin
                     $display("ERR out_last test %0d word %0d: got %h expected %h",
                              et, got_words[et], out_last, el);
                     err_count++;
                     test_errs[et]++;
                  end
                  got_words[et]++;
                  if (el)
                     $display("test %0d: reply of %0d words done, %0d errors",
                              et, got_words[et], test_errs[et]);
               end
            end
            prev_hold = out_valid && !out_ready;
            prev_data = out_data;
            prev_last = out_last;
         end
      end
   end

   // Budget of 40 cycles plus 64 per block and three times that under random stalls
   function automatic int timeout_cycles();
      int total;
      int cyc;
      total = 5 + 40;
      for (int i = 0; i < NUM_TESTS; i++) begin
         cyc = rows[i].is_ctrl ? 40 : 40 + 64 * (1 << (rows[i].size - 4));
         if (rows[i].stall)
            cyc = cyc * 3;
         total += cyc;
      end
      return total;
   endfunction

   initial begin
      int limit;
      limit = timeout_cycles();
      repeat (limit) @(posedge clk_ctrl);
      $display("timeout after %0d cycles, the output never completed", limit);
      $display("Test FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int passed;
      void'($urandom(32'h5d7a));
      clk_ctrl_rst_low = 1'b0;
      src_tile         = TILE_ID;
      in_valid         = 1'b0;
      in_data          = '0;
      in_last          = 1'b0;
      repeat (5) @(posedge clk_ctrl);
      #1;
      clk_ctrl_rst_low = 1'b1;
      @(posedge clk_ctrl);
      if (out_valid !== 1'b0) begin
         $display("ERR out_valid after reset: got %h expected %h", out_valid, 1'b0);
         err_count++;
      end
      if (in_ready !== 1'b1) begin
         $display("ERR in_ready after reset: got %h expected %h", in_ready, 1'b1);
         err_count++;
      end
      #1;

      for (int t = 0; t < NUM_TESTS; t++) begin
         cur_test = t;
         stall_on = rows[t].stall;
         if (rows[t].is_ctrl) begin
            send_word(32'h0000_0001, 1'b0);   // Short header with the long flag clear
            send_word(32'h8000_0000, 1'b1);
            in_valid = 1'b0;
            in_last  = 1'b0;
            $display("test %0d: control toggle sent", t);
         end else if (!rows[t].expect_out) begin
            wait_drain();
            make_samples(rows[t].size);
            send_long(rows[t]);
            repeat (NO_OUT_WINDOW) @(posedge clk_ctrl);
            #1;
            $display("test %0d: packet dropped while disabled, %0d errors", t, test_errs[t]);
         end else begin
            make_samples(rows[t].size);
            queue_reply(t, rows[t]);
            send_long(rows[t]);                // Back to back with earlier replies
         end
      end

      stall_on = 1'b0;
      wait_drain();
      repeat (30) @(posedge clk_ctrl);        // Catch trailing stray words

      if (in_stalls == 0) begin
         $display("in_ready never stalled during the back-pressure tests");
         err_count++;
      end

      passed = 0;
      for (int t = 0; t < NUM_TESTS; t++)
         if (test_errs[t] == 0)
            passed++;
      $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d in_ready stall cycles",
               NUM_TESTS, passed, NUM_TESTS - passed, err_count, in_stalls);
      if (err_count == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

/* design/butterfly_stage.sv */
// Compute stage fed by the decoder that runs the first radix-2 DIF butterfly in two registers
`include "fft_acc_macros.svh"

module butterfly_stage import fft_acc_pkg::*; (
   input  logic   clk_ctrl,
   input  logic   clk_ctrl_rst_low,
   input  logic   blk_valid,
   input  block_t blk_data,
   output logic   res_valid,
   output block_t res_data
);

   localparam int W    = `FFT_WORD_W;
   localparam int HALF = `FFT_POINTS / 2;

   logic   s1_valid;
   block_t s1_data;

   // Re of sample k at word 2k and Im at word 2k+1
   function automatic word_t part_of(block_t blk, int idx);
      return blk[idx*W +: W];
   endfunction

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         s1_valid  <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         s1_valid  <= blk_valid;
         res_valid <= s1_valid;
      end
   end

   //////////////////////////////////////////////////
   // Sum and difference of samples k and k+4
   //////////////////////////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      s1_data <= blk_data;
      for (int k = 0; k < HALF; k++) begin
         for (int p = 0; p < 2; p++) begin
            res_data[(2*k+p)*W +: W] <=
               part_of(s1_data, 2*k+p) + part_of(s1_data, 2*(k+HALF)+p);
            res_data[(2*(k+HALF)+p)*W +: W] <=
               part_of(s1_data, 2*k+p) - part_of(s1_data, 2*(k+HALF)+p); // Wraps
         end
      end
   end

   // Sum plus difference gives twice the Re part of sample 0 two cycles back
   assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      res_valid |-> (word_t'(part_of(res_data, 0) + part_of(res_data, 2*HALF))
                     == word_t'($past(part_of(blk_data, 0), 2) << 1)))
      else $error("butterfly result does not match the block two cycles earlier");

endmodule

/* design/fft_acc_macros.svh */
// Shared widths, depths, opcodes and header field positions; include wherever a constant is needed
`ifndef FFT_ACC_MACROS_SVH
`define FFT_ACC_MACROS_SVH

`define FFT_WORD_W          32            // Stream word and sample part
`define FFT_POINTS          8             // Complex samples per block
`define FFT_BLK_WORDS       16            // Re/Im words per block
`define FFT_HDR_FIFO_DEPTH  8
`define FFT_BLK_FIFO_DEPTH  4

`define FFT_OP_QPUT         3'd3
`define FFT_OP_MPUT         3'd4
`define FFT_CTRL_TOGGLE     32'h8000_0000 // Flips the accelerator enable
`define FFT_SZ_BASE         4             // Size code of a one-block packet

// Header field positions
`define FFT_HDR_LONG_BIT    28
`define FFT_HDR_OP_HI       27
`define FFT_HDR_OP_LO       25
`define FFT_HDR_SRC_HI      23
`define FFT_HDR_SRC_LO      18
`define FFT_HDR_SZ_HI       11
`define FFT_HDR_SZ_LO       8
`define FFT_HDR_RT_HI       9             // Second header word
`define FFT_HDR_RT_LO       8
`define FFT_HDR_LOW_HI      5
`define FFT_HDR_LOW_LO      0

`endif

/* design/fft_acc_pkg.sv */
// Vector types and FSM state encodings shared by the accelerator tile, compiled first
`include "fft_acc_macros.svh"

package fft_acc_pkg;

   typedef logic [`FFT_WORD_W-1:0]                  word_t;
   typedef logic [`FFT_BLK_WORDS*`FFT_WORD_W-1:0]   block_t;  // Word n at bits 32n and up
   typedef logic [`FFT_HDR_SRC_HI-`FFT_HDR_SRC_LO:0] node_id_t;
   typedef logic [`FFT_HDR_SZ_HI-`FFT_HDR_SZ_LO:0]   size_code_t;
   typedef logic [`FFT_HDR_RT_HI-`FFT_HDR_RT_LO:0]   route_t;
   typedef logic [7:0]                              blk_cnt_t;

   //////////////////////////////////////////////////
   // FSM states
   //////////////////////////////////////////////////

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_HDR2,
      RX_DATA,
      RX_DISCARD,   // Long packet while disabled
      RX_CTRL
   } rx_state_t;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_HDR1,
      TX_HDR2,
      TX_DATA,
      TX_WAIT       // Next block not yet in the FIFO
   } tx_state_t;

endpackage

/* design/fft_acc_top.sv */
// Accelerator tile top: decoder, butterfly stage, header and block FIFOs, encoder
`include "fft_acc_macros.svh"

module fft_acc_top import fft_acc_pkg::*; (
   input  logic     clk_ctrl,
   input  logic     clk_ctrl_rst_low,
   input  node_id_t src_tile,
   input  logic     in_valid,
   input  word_t    in_data,
   input  logic     in_last,
   output logic     in_ready,
   output logic     out_valid,
   output word_t    out_data,
   output logic     out_last,
   input  logic     out_ready
);

   logic   hdr_wr, hdr_rd, hdr_empty, hdr_almost_full;
   word_t  hdr_din, hdr_dout;
   logic   blk_valid, res_valid;
   block_t blk_data, res_data;
   logic   blk_rd, blk_empty, blk_almost_full;
   block_t blk_dout;

   //////////////////////////////////////////////////
   // Input path
   //////////////////////////////////////////////////

   noc_rx_decoder u_rx_decoder (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .src_tile        (src_tile),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_last         (in_last),
      .hdr_almost_full (hdr_almost_full),
      .blk_almost_full (blk_almost_full),
      .in_ready        (in_ready),
      .hdr_wr          (hdr_wr),
      .hdr_din         (hdr_din),
      .blk_valid       (blk_valid),
      .blk_data        (blk_data)
   );

   butterfly_stage u_butterfly (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .blk_valid       (blk_valid),
      .blk_data        (blk_data),
      .res_valid       (res_valid),
      .res_data        (res_data)
   );

   sync_fifo #(.WIDTH($bits(word_t)), .DEPTH(`FFT_HDR_FIFO_DEPTH)) u_hdr_fifo (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .wr              (hdr_wr),
      .din             (hdr_din),
      .rd              (hdr_rd),
      .dout            (hdr_dout),
      .empty           (hdr_empty),
      .almost_full     (hdr_almost_full)
   );

   sync_fifo #(.WIDTH($bits(block_t)), .DEPTH(`FFT_BLK_FIFO_DEPTH)) u_blk_fifo (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .wr              (res_valid),    // Butterfly results push directly
      .din             (res_data),
      .rd              (blk_rd),
      .dout            (blk_dout),
      .empty           (blk_empty),
      .almost_full     (blk_almost_full)
   );

   // Output path
   noc_tx_encoder u_tx_encoder (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .out_ready       (out_ready),
      .hdr_dout        (hdr_dout),
      .hdr_empty       (hdr_empty),
      .blk_dout        (blk_dout),
      .blk_empty       (blk_empty),
      .out_valid       (out_valid),
      .out_data        (out_data),
      .out_last        (out_last),
      .hdr_rd          (hdr_rd),
      .blk_rd          (blk_rd)
   );

endmodule

/* design/noc_rx_decoder.sv */
// Tile input decoder instantiated by the top level that parses NoC headers and assembles blocks
`include "fft_acc_macros.svh"

module noc_rx_decoder import fft_acc_pkg::*; (
   input  logic     clk_ctrl,
   input  logic     clk_ctrl_rst_low,
   input  node_id_t src_tile,
   input  logic     in_valid,
   input  word_t    in_data,
   input  logic     in_last,
   input  logic     hdr_almost_full,
   input  logic     blk_almost_full,
   output logic     in_ready,
   output logic     hdr_wr,
   output word_t    hdr_din,
   output logic     blk_valid,
   output block_t   blk_data
);

   localparam int IDX_W = $clog2(`FFT_BLK_WORDS);
   localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`FFT_BLK_WORDS - 1);

   rx_state_t        state;
   logic             acc_en;      // Toggled by control packets
   word_t            hdr1_q;      // First input header word
   word_t            hdr2_q;      // Second reply word pushed with the first data word
   logic             hdr2_pend;
   logic [IDX_W-1:0] word_idx;
   logic             xfer;
   route_t           route;
   size_code_t       sz_code;
   word_t            hdr1_out;
   word_t            hdr2_out;

   assign xfer    = in_valid & in_ready;
   assign route   = in_data[`FFT_HDR_RT_HI:`FFT_HDR_RT_LO];
   assign sz_code = hdr1_q[`FFT_HDR_SZ_HI:`FFT_HDR_SZ_LO];

   // Stall only at packet start or at the start of a later block
   always_comb begin
      case (state)
         RX_IDLE: in_ready = ~(hdr_almost_full | blk_almost_full);
         RX_DATA: in_ready = hdr2_pend | (word_idx != '0) | ~blk_almost_full;
         default: in_ready = 1'b1;
      endcase
   end

   //////////////////////////////////////////////////
   // Reply header rebuild on header word two
   //////////////////////////////////////////////////

   always_comb begin
      hdr1_out = '0;
      hdr2_out = '0;
      hdr1_out[`FFT_HDR_LONG_BIT]                = 1'b1;
      hdr1_out[`FFT_HDR_SRC_HI:`FFT_HDR_SRC_LO]  = src_tile;
      hdr1_out[`FFT_HDR_SZ_HI:`FFT_HDR_SZ_LO]    = sz_code;
      case (route)
         2'b01: begin // Forward back to the source
            hdr1_out[`FFT_HDR_OP_HI:`FFT_HDR_OP_LO]   = `FFT_OP_MPUT;
            hdr1_out[`FFT_HDR_LOW_HI:`FFT_HDR_LOW_LO] = in_data[`FFT_HDR_LOW_HI:`FFT_HDR_LOW_LO];
            hdr2_out[`FFT_HDR_RT_HI:`FFT_HDR_RT_LO]   = 2'b10;
            hdr2_out[`FFT_HDR_LOW_HI:`FFT_HDR_LOW_LO] = hdr1_q[`FFT_HDR_SRC_HI:`FFT_HDR_SRC_LO];
         end
         2'b10: begin // Final send
            hdr1_out[`FFT_HDR_OP_HI:`FFT_HDR_OP_LO]   = `FFT_OP_QPUT;
            hdr1_out[`FFT_HDR_LOW_HI:`FFT_HDR_LOW_LO] = in_data[`FFT_HDR_LOW_HI:`FFT_HDR_LOW_LO];
         end
         default: begin
            hdr1_out[`FFT_HDR_OP_HI:`FFT_HDR_OP_LO]   = `FFT_OP_MPUT; // Loop with low field zero
         end
      endcase
   end

   assign hdr_wr  = xfer & ((state == RX_HDR2) | ((state == RX_DATA) & hdr2_pend));
   assign hdr_din = (state == RX_HDR2) ? hdr1_out : hdr2_q;

   //////////////////////////////////////////////////
   // Packet FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state     <= RX_IDLE;
         acc_en    <= 1'b0;
         hdr2_pend <= 1'b0;
         word_idx  <= '0;
         blk_valid <= 1'b0;
      end else begin
         blk_valid <= 1'b0;
         if (xfer) begin
            case (state)
               RX_IDLE: begin
                  if (!in_data[`FFT_HDR_LONG_BIT])
                     state <= RX_CTRL;
                  else if (acc_en)
                     state <= RX_HDR2;
                  else if (!in_last)
                     state <= RX_DISCARD;   // Drop the whole packet
               end
               RX_HDR2: begin
                  hdr2_pend <= 1'b1;
                  word_idx  <= '0;
                  state     <= RX_DATA;
               end
               RX_DATA: begin
                  hdr2_pend <= 1'b0;
                  word_idx  <= word_idx + 1'b1;  // Wraps to the next block
                  if (word_idx == IDX_LAST) begin
                     blk_valid <= 1'b1;
                     if (in_last)
                        state <= RX_IDLE;
                  end
               end
               RX_DISCARD: begin
                  if (in_last)
                     state <= RX_IDLE;
               end
               RX_CTRL: begin
                  if (in_data == `FFT_CTRL_TOGGLE)
                     acc_en <= ~acc_en;
                  state <= RX_IDLE;
               end
               default: state <= RX_IDLE;
            endcase
         end
      end
   end

   // Header and sample capture
   always_ff @(posedge clk_ctrl) begin
      if (xfer && state == RX_IDLE)
         hdr1_q <= in_data;
      if (xfer && state == RX_HDR2)
         hdr2_q <= hdr2_out;
      if (xfer && state == RX_DATA)
         blk_data[word_idx*`FFT_WORD_W +: `FFT_WORD_W] <= in_data;
   end

   // The first header push of a packet finds the header FIFO below almost full
   assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      (hdr_wr && state == RX_HDR2) |-> !hdr_almost_full)
      else $error("header push into an almost full header FIFO at packet start");

endmodule

/* design/noc_tx_encoder.sv */
// Output side of the tile: sends the two reply header words, then serializes each result block
`include "fft_acc_macros.svh"

module noc_tx_encoder import fft_acc_pkg::*; (
   input  logic   clk_ctrl,
   input  logic   clk_ctrl_rst_low,
   input  logic   out_ready,
   input  word_t  hdr_dout,
   input  logic   hdr_empty,
   input  block_t blk_dout,
   input  logic   blk_empty,
   output logic   out_valid,
   output word_t  out_data,
   output logic   out_last,
   output logic   hdr_rd,
   output logic   blk_rd
);

   localparam int IDX_W = $clog2(`FFT_BLK_WORDS);
   localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`FFT_BLK_WORDS - 1);

   tx_state_t        state;
   blk_cnt_t         blk_cnt;     // Blocks still to send
   logic [IDX_W-1:0] word_idx;
   size_code_t       sz_code;
   logic             last_word;

   assign sz_code   = hdr_dout[`FFT_HDR_SZ_HI:`FFT_HDR_SZ_LO];
   assign last_word = (word_idx == IDX_LAST);

   // Outputs follow the state only, so they hold while out_ready is low
   always_comb begin
      out_valid = 1'b0;
      out_data  = '0;
      out_last  = 1'b0;
      hdr_rd    = 1'b0;
      blk_rd    = 1'b0;
      case (state)
         TX_HDR1, TX_HDR2: begin
            out_valid = 1'b1;
            out_data  = hdr_dout;
            hdr_rd    = out_ready;
         end
         TX_DATA: begin
            out_valid = 1'b1;
            out_data  = blk_dout[word_idx*`FFT_WORD_W +: `FFT_WORD_W];
            out_last  = last_word & (blk_cnt == blk_cnt_t'(1));
            blk_rd    = out_ready & last_word;  // Block done
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////
   // Packet FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state    <= TX_IDLE;
         blk_cnt  <= '0;
         word_idx <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (!hdr_empty && !blk_empty)
                  state <= TX_HDR1;
            end
            TX_HDR1: begin
               if (out_ready) begin
                  blk_cnt <= blk_cnt_t'(1) << (sz_code - `FFT_SZ_BASE);
                  state   <= TX_HDR2;
               end
            end
            TX_HDR2: begin
               if (out_ready) begin
                  word_idx <= '0;
                  state    <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (out_ready) begin
                  word_idx <= word_idx + 1'b1;
                  if (last_word) begin
                     blk_cnt <= blk_cnt - 1'b1;
                     state   <= (blk_cnt == blk_cnt_t'(1)) ? TX_IDLE : TX_WAIT;
                  end
               end
            end
            TX_WAIT: begin
               if (!blk_empty)
                  state <= TX_DATA;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

/* design/sync_fifo.sv */
// Show-ahead single-clock FIFO with almost-full flag, used for reply headers and result blocks
module sync_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 8     // Power of two
)(
   input  logic             clk_ctrl,
   input  logic             clk_ctrl_rst_low,
   input  logic             wr,
   input  logic [WIDTH-1:0] din,
   input  logic             rd,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             almost_full
);

   localparam int PTR_W    = $clog2(DEPTH);
   localparam int AF_LEVEL = DEPTH - DEPTH / 4;   // Three quarters full

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             full;

   assign dout        = mem[rd_ptr];  // Oldest entry, visible before the pop
   assign empty       = (count == '0);
   assign full        = (count == (PTR_W+1)'(DEPTH));
   assign almost_full = (count >= (PTR_W+1)'(AF_LEVEL));

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_ctrl) begin
      if (wr)
         mem[wr_ptr] <= din;
   end

   //////////////////////////////////////////////////
   // Overflow and underflow
   //////////////////////////////////////////////////

   assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low) !(wr && full))
      else $error("push into full FIFO");

   assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low) !(rd && empty))
      else $error("pop from empty FIFO");

endmodule

/* verilog.f */
+incdir+design
design/fft_acc_pkg.sv
design/noc_rx_decoder.sv
design/butterfly_stage.sv
design/sync_fifo.sv
design/noc_tx_encoder.sv
design/fft_acc_top.sv
bench/fft_acc_tb.sv
